//--- tb.f
+incdir+tb
src/cache_geom_pkg.sv
src/cache_ctrl_pkg.sv
src/tag_if.sv
src/data_if.sv
src/tag_array.sv
src/data_array.sv
src/cache_ctrl.sv
src/cache_top.sv
tb/cache_tb.sv

//--- tb/cache_vectors.svh
// columns: op, byte address, write strobes, write data, expected read data
// sets 0 and 1 only; tags 0x1, 0x2, 0x3 share set 0 to force evictions
task automatic load_vectors;
    // cold miss, then hits on the same line
    add_row(cache_ctrl_pkg::OP_READ,  32'h0000_0100, 4'b0000, 32'h0000_0000, 32'hffff_ffbf);
    add_row(cache_ctrl_pkg::OP_READ,  32'h0000_0104, 4'b0000, 32'h0000_0000, 32'hffff_ffbe);
    // partial write hit, read forwarded from the write buffer
    add_row(cache_ctrl_pkg::OP_WRITE, 32'h0000_0108, 4'b0011, 32'h1234_5678, 32'h0000_0000);
    add_row(cache_ctrl_pkg::OP_READ,  32'h0000_0108, 4'b0000, 32'h0000_0000, 32'hffff_5678);
    add_row(cache_ctrl_pkg::OP_READ,  32'h0000_010c, 4'b0000, 32'h0000_0000, 32'hffff_ffbc);
    // write miss into the free way
    add_row(cache_ctrl_pkg::OP_WRITE, 32'h0000_0204, 4'b1100, 32'haabb_ccdd, 32'h0000_0000);
    add_row(cache_ctrl_pkg::OP_READ,  32'h0000_0204, 4'b0000, 32'h0000_0000, 32'haabb_ff7e);
    // third tag evicts dirty 0x100, then 0x100 evicts dirty 0x200
    add_row(cache_ctrl_pkg::OP_READ,  32'h0000_0300, 4'b0000, 32'h0000_0000, 32'hffff_ff3f);
    add_row(cache_ctrl_pkg::OP_READ,  32'h0000_0100, 4'b0000, 32'h0000_0000, 32'hffff_ffbf);
    add_row(cache_ctrl_pkg::OP_READ,  32'h0000_0108, 4'b0000, 32'h0000_0000, 32'hffff_5678);
    // clean victims, no write-back
    add_row(cache_ctrl_pkg::OP_READ,  32'h0000_0204, 4'b0000, 32'h0000_0000, 32'haabb_ff7e);
    add_row(cache_ctrl_pkg::OP_READ,  32'h0000_0304, 4'b0000, 32'h0000_0000, 32'hffff_ff3e);
    // set 1, full word write miss then back to back write and read
    add_row(cache_ctrl_pkg::OP_WRITE, 32'h0000_0410, 4'b1111, 32'hdead_beef, 32'h0000_0000);
    add_row(cache_ctrl_pkg::OP_READ,  32'h0000_0414, 4'b0000, 32'h0000_0000, 32'hffff_fefa);
    add_row(cache_ctrl_pkg::OP_WRITE, 32'h0000_0414, 4'b0001, 32'h0000_0055, 32'h0000_0000);
    add_row(cache_ctrl_pkg::OP_READ,  32'h0000_0414, 4'b0000, 32'h0000_0000, 32'hffff_fe55);
    add_row(cache_ctrl_pkg::OP_READ,  32'h0000_0410, 4'b0000, 32'h0000_0000, 32'hdead_beef);
endtask

//--- tb/cache_tb.sv
`timescale 1ns/10ps

module cache_tb;

    logic                    clk;
    logic                    reset;
    logic                    valid;
    cache_ctrl_pkg::mem_op_e op;
    logic [31:0]             addr;
    logic [3:0]              wstrb;
    logic [31:0]             wdata;
    logic                    addr_ok;
    logic                    data_ok;
    logic [31:0]             rdata;
    logic                    rd_req;
    logic [31:0]             rd_addr;
    logic                    rd_rdy;
    logic                    ret_valid;
    logic                    ret_last;
    logic [31:0]             ret_data;
    logic                    wr_req;
    logic [31:0]             wr_addr;
    logic [127:0]            wr_data;
    logic                    wr_rdy;

    cache_ctrl_pkg::mem_op_e vec_op[$];
    logic [31:0]             vec_addr[$];
    logic [3:0]              vec_strb[$];
    logic [31:0]             vec_data[$];
    logic [31:0]             vec_exp[$];

    cache_ctrl_pkg::mem_op_e pend_op[$];   // accepted, waiting for data_ok
    logic [31:0]             pend_exp[$];
    logic [31:0]             wb_addr_q[$]; // predicted write-backs
    logic [127:0]            wb_line_q[$];
    logic [31:0]             refill_q[$];  // predicted line reads

    logic [7:0]  shadow [logic [31:0]];
    logic [31:0] mem_words [logic [31:0]];
    logic [23:0] m_tag [16][2];
    logic        m_valid [16][2];
    logic        m_dirty [16][2];
    logic        m_rr [16];

    integer seed = 32'h1e47;
    int     errors = 0;
    int     cycles = 0;
    int     accepted_rows = 0;
    int     limit;

    cache_top i_cache_top (.*);

    task automatic add_row(cache_ctrl_pkg::mem_op_e o, logic [31:0] a, logic [3:0] s,
                           logic [31:0] d, logic [31:0] e);
        vec_op.push_back(o);
        vec_addr.push_back(a);
        vec_strb.push_back(s);
        vec_data.push_back(d);
        vec_exp.push_back(e);
    endtask

    `include "cache_vectors.svh"

    function automatic logic [7:0] expected_byte(logic [31:0] a);
        logic [31:0] w;
        if (shadow.exists(a))
            return shadow[a];
        w = ~(a >> 2);  // memory starts as inverted word address
        return w[a[1:0]*8 +: 8];
    endfunction

    function automatic logic [127:0] shadow_line(logic [31:0] base);
        logic [127:0] line;
        for (int k = 0; k < 16; k++)
            line[k*8 +: 8] = expected_byte(base + k);
        return line;
    endfunction

    function automatic logic [31:0] mem_read(logic [31:0] wa);
        if (mem_words.exists(wa))
            return mem_words[wa];
        return ~wa;
    endfunction

    // mirror of the set state, predicts victims and write-backs
    task automatic track_access(cache_ctrl_pkg::mem_op_e o, logic [31:0] a, logic [3:0] s,
                                logic [31:0] d);
        int set;
        int hit_w;
        int vic;
        set   = a[7:4];
        hit_w = -1;
        for (int w = 0; w < 2; w++)
            if (m_valid[set][w] && m_tag[set][w] == a[31:8])
                hit_w = w;
        if (hit_w >= 0) begin
            if (o == cache_ctrl_pkg::OP_WRITE)
                m_dirty[set][hit_w] = 1'b1;
        end else begin
            vic = !m_valid[set][0] ? 0 : (!m_valid[set][1] ? 1 : int'(m_rr[set]));
            if (m_valid[set][vic] && m_dirty[set][vic]) begin
                wb_addr_q.push_back({m_tag[set][vic], a[7:4], 4'h0});
                wb_line_q.push_back(shadow_line({m_tag[set][vic], a[7:4], 4'h0}));
            end
            refill_q.push_back({a[31:4], 4'h0});
            m_tag[set][vic]   = a[31:8];
            m_valid[set][vic] = 1'b1;
            m_dirty[set][vic] = (o == cache_ctrl_pkg::OP_WRITE);
            m_rr[set]         = !m_rr[set];
        end
        if (o == cache_ctrl_pkg::OP_WRITE)
            for (int b = 0; b < 4; b++)
                if (s[b])
                    shadow[{a[31:2], 2'b00} + b] = d[b*8 +: 8];
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // memory ready levels, low now and then
    always @(posedge clk) begin
        #1;
        rd_rdy = ($random(seed) & 3) != 0;
        wr_rdy = ($random(seed) & 3) != 0;
    end

    // memory model
    initial begin
        int gap;
        logic [31:0] base;
        forever begin
            @(posedge clk);
            if (!reset && wr_req)
                for (int k = 0; k < 4; k++)
                    mem_words[(wr_addr >> 2) + k] = wr_data[k*32 +: 32];
            if (!reset && rd_req && rd_rdy) begin
                base = rd_addr >> 2;
                for (int k = 0; k < 4; k++) begin
                    gap = $random(seed) & 3;
                    repeat (gap) @(posedge clk);
                    #1;
                    ret_valid = 1'b1;
                    ret_last  = (k == 3);
                    ret_data  = mem_read(base + k);
                    @(posedge clk);
                    #1;
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

    // response checks, sampled on the edge
    always @(posedge clk) begin
        if (!reset) begin
            if (data_ok) begin
                assert (pend_op.size() > 0) else begin
                    errors++;
                    $display("data_ok at %0t with no request outstanding", $time);
                end
                if (pend_op.size() > 0) begin
                    if (pend_op[0] == cache_ctrl_pkg::OP_READ)
                        assert (rdata === pend_exp[0]) else begin
                            errors++;
                            $display("Mismatch at %0t: rdata expected %h got %h",
                                     $time, pend_exp[0], rdata);
                        end
                    void'(pend_op.pop_front());
                    void'(pend_exp.pop_front());
                end
            end
            if (rd_req && rd_rdy) begin
                assert (refill_q.size() > 0) else begin
                    errors++;
                    $display("rd_req at %0t while no miss was expected", $time);
                end
                if (refill_q.size() > 0) begin
                    assert (rd_addr === refill_q[0]) else begin
                        errors++;
                        $display("Mismatch at %0t: rd_addr expected %h got %h",
                                 $time, refill_q[0], rd_addr);
                    end
                    void'(refill_q.pop_front());
                end
            end
            if (valid && addr_ok) begin
                pend_op.push_back(op);
                pend_exp.push_back(vec_exp[accepted_rows]);
                accepted_rows++;
                track_access(op, addr, wstrb, wdata);
            end
            if (wr_req) begin
                assert (wb_addr_q.size() > 0) else begin
                    errors++;
                    $display("wr_req at %0t while no dirty eviction was expected", $time);
                end
                if (wb_addr_q.size() > 0) begin
                    assert (wr_addr === wb_addr_q[0]) else begin
                        errors++;
                        $display("Mismatch at %0t: wr_addr expected %h got %h",
                                 $time, wb_addr_q[0], wr_addr);
                    end
                    assert (wr_data === wb_line_q[0]) else begin
                        errors++;
                        $display("Mismatch at %0t: wr_data expected %h got %h",
                                 $time, wb_line_q[0], wr_data);
                    end
                    void'(wb_addr_q.pop_front());
                    void'(wb_line_q.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, %0d responses outstanding",
                     cycles, pend_op.size());
            $display("errors: %0d", errors + 1);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int accepted;
        limit     = 0;
        reset     = 1'b1;
        valid     = 1'b0;
        op        = cache_ctrl_pkg::OP_READ;
        addr      = '0;
        wstrb     = '0;
        wdata     = '0;
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        for (int s = 0; s < 16; s++) begin
            m_rr[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        load_vectors();
        limit = vec_op.size() * 60;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        // pipelined issue, next row goes out right after acceptance
        for (int i = 0; i < vec_op.size(); i++) begin
            valid = 1'b1;
            op    = vec_op[i];
            addr  = vec_addr[i];
            wstrb = vec_strb[i];
            wdata = vec_data[i];
            do begin
                @(posedge clk);
                accepted = addr_ok;
            end while (!accepted);
            #1;
        end
        valid = 1'b0;
        while (pend_op.size() > 0)
            @(posedge clk);
        repeat (4) @(posedge clk);
        assert (wb_addr_q.size() == 0) else begin
            errors++;
            $display("missing wr_req for %0d dirty evictions", wb_addr_q.size());
        end
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- src/cache_top.sv
`timescale 1ns/10ps

module cache_top #(
    parameter int NUM_WAY        = cache_geom_pkg::DEF_NUM_WAY,
    parameter int BYTES_PER_LINE = cache_geom_pkg::DEF_BYTES_PER_LINE,
    parameter int NUM_LINE       = cache_geom_pkg::DEF_NUM_LINE
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 valid,
    input  cache_ctrl_pkg::mem_op_e              op,
    input  logic [cache_geom_pkg::ADDR_BITS-1:0] addr,
    input  logic [cache_geom_pkg::STRB_BITS-1:0] wstrb,
    input  logic [cache_geom_pkg::WORD_BITS-1:0] wdata,
    output logic                                 addr_ok,
    output logic                                 data_ok,
    output logic [cache_geom_pkg::WORD_BITS-1:0] rdata,
    output logic                                 rd_req,
    output logic [cache_geom_pkg::ADDR_BITS-1:0] rd_addr,
    input  logic                                 rd_rdy,
    input  logic                                 ret_valid,
    input  logic                                 ret_last,
    input  logic [cache_geom_pkg::WORD_BITS-1:0] ret_data,
    output logic                                 wr_req,
    output logic [cache_geom_pkg::ADDR_BITS-1:0] wr_addr,
    output logic [BYTES_PER_LINE*8-1:0]          wr_data,
    input  logic                                 wr_rdy
);

    tag_if #(
        .NUM_WAY        (NUM_WAY),
        .BYTES_PER_LINE (BYTES_PER_LINE),
        .NUM_LINE       (NUM_LINE)
    ) tag_bus ();

    data_if #(
        .NUM_WAY        (NUM_WAY),
        .BYTES_PER_LINE (BYTES_PER_LINE),
        .NUM_LINE       (NUM_LINE)
    ) data_bus ();

    cache_ctrl #(
        .NUM_WAY        (NUM_WAY),
        .BYTES_PER_LINE (BYTES_PER_LINE),
        .NUM_LINE       (NUM_LINE)
    ) i_cache_ctrl (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .op        (op),
        .addr      (addr),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy),
        .tags      (tag_bus.ctrl),
        .data      (data_bus.ctrl)
    );

    tag_array #(
        .NUM_WAY        (NUM_WAY),
        .BYTES_PER_LINE (BYTES_PER_LINE),
        .NUM_LINE       (NUM_LINE)
    ) i_tag_array (
        .clk   (clk),
        .reset (reset),
        .tags  (tag_bus.store)
    );

    data_array #(
        .NUM_WAY        (NUM_WAY),
        .BYTES_PER_LINE (BYTES_PER_LINE),
        .NUM_LINE       (NUM_LINE)
    ) i_data_array (
        .clk  (clk),
        .data (data_bus.store)
    );

endmodule

//--- src/cache_ctrl.sv
`timescale 1ns/10ps

module cache_ctrl #(
    parameter int NUM_WAY        = cache_geom_pkg::DEF_NUM_WAY,
    parameter int BYTES_PER_LINE = cache_geom_pkg::DEF_BYTES_PER_LINE,
    parameter int NUM_LINE       = cache_geom_pkg::DEF_NUM_LINE
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 valid,
    input  cache_ctrl_pkg::mem_op_e              op,
    input  logic [cache_geom_pkg::ADDR_BITS-1:0] addr,
    input  logic [cache_geom_pkg::STRB_BITS-1:0] wstrb,
    input  logic [cache_geom_pkg::WORD_BITS-1:0] wdata,
    output logic                                 addr_ok,
    output logic                                 data_ok,
    output logic [cache_geom_pkg::WORD_BITS-1:0] rdata,
    output logic                                 rd_req,
    output logic [cache_geom_pkg::ADDR_BITS-1:0] rd_addr,
    input  logic                                 rd_rdy,
    input  logic                                 ret_valid,
    input  logic                                 ret_last,
    input  logic [cache_geom_pkg::WORD_BITS-1:0] ret_data,
    output logic                                 wr_req,
    output logic [cache_geom_pkg::ADDR_BITS-1:0] wr_addr,
    output logic [BYTES_PER_LINE*8-1:0]          wr_data,
    input  logic                                 wr_rdy,
    tag_if.ctrl                                  tags,
    data_if.ctrl                                 data
);
    localparam int WORD_BITS   = cache_geom_pkg::WORD_BITS;
    localparam int STRB_BITS   = cache_geom_pkg::STRB_BITS;
    localparam int OFFSET_BITS = $clog2(BYTES_PER_LINE);
    localparam int INDEX_BITS  = $clog2(NUM_LINE);
    localparam int TAG_BITS    = cache_geom_pkg::ADDR_BITS - OFFSET_BITS - INDEX_BITS;
    localparam int BANK_BITS   = $clog2(BYTES_PER_LINE / STRB_BITS);
    localparam int LINE_BITS   = BYTES_PER_LINE * 8;

    function automatic logic [WORD_BITS-1:0] merge_bytes(
        input logic [WORD_BITS-1:0] old_word,
        input logic [WORD_BITS-1:0] new_word,
        input logic [STRB_BITS-1:0] strb
    );
        logic [WORD_BITS-1:0] result;
        result = old_word;
        for (int b = 0; b < STRB_BITS; b++) begin
            if (strb[b])
                result[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return result;
    endfunction

    cache_ctrl_pkg::cache_state_e state;
    cache_ctrl_pkg::cache_state_e state_next;

    // request buffer, held until the next acceptance
    cache_ctrl_pkg::mem_op_e req_op;
    logic [TAG_BITS-1:0]     req_tag;
    logic [INDEX_BITS-1:0]   req_index;
    logic [BANK_BITS-1:0]    req_bank;
    logic [STRB_BITS-1:0]    req_wstrb;
    logic [WORD_BITS-1:0]    req_wdata;

    // replace buffer
    logic [NUM_WAY-1:0]      rep_way;
    logic [TAG_BITS-1:0]     rep_tag;
    logic [LINE_BITS-1:0]    rep_line;

    // write buffer
    logic                    wbuf_busy;
    logic [NUM_WAY-1:0]      wbuf_way;
    logic [INDEX_BITS-1:0]   wbuf_index;
    logic [BANK_BITS-1:0]    wbuf_bank;
    logic [STRB_BITS-1:0]    wbuf_strb;
    logic [WORD_BITS-1:0]    wbuf_data;

    logic [BANK_BITS-1:0]    refill_cnt;
    logic                    first_replace;

    logic                    in_lookup;
    logic                    in_refill;
    logic                    hit;
    logic                    hit_write;
    logic                    req_write;
    logic                    wbuf_on_line;
    logic                    wbuf_on_victim;
    logic                    victim_dirty;
    logic                    fill_done;
    logic [STRB_BITS-1:0]    fwd_strb;
    logic [WORD_BITS-1:0]    hit_word;
    logic [WORD_BITS-1:0]    lookup_rdata;
    logic [WORD_BITS-1:0]    refill_word;
    logic [LINE_BITS-1:0]    victim_line;

    assign in_lookup = (state == cache_ctrl_pkg::LOOKUP);
    assign in_refill = (state == cache_ctrl_pkg::REFILL);
    assign req_write = (req_op == cache_ctrl_pkg::OP_WRITE);
    assign hit       = in_lookup && (|tags.hit_way);
    assign hit_write = hit && req_write;
    assign fill_done = in_refill && ret_valid && ret_last;

    // pending write on the same bank blocks acceptance
    assign addr_ok = valid && !(wbuf_busy && (wbuf_bank == addr[OFFSET_BITS-1 -: BANK_BITS]))
                     && ((state == cache_ctrl_pkg::IDLE) || hit);

    assign wbuf_on_line   = wbuf_busy && (wbuf_index == req_index);
    assign wbuf_on_victim = wbuf_on_line && (wbuf_way == tags.victim_way);
    assign fwd_strb       = (wbuf_on_line && (wbuf_way == tags.hit_way) && (wbuf_bank == req_bank))
                            ? wbuf_strb : '0;
    assign victim_dirty   = (|(tags.victim_way & tags.valid_ways & tags.dirty_ways))
                            || wbuf_on_victim;

    always_comb begin
        hit_word    = '0;
        victim_line = '0;
        for (int w = 0; w < NUM_WAY; w++) begin
            if (tags.hit_way[w])
                hit_word = hit_word | data.way_words[w];
            if (tags.victim_way[w])
                victim_line = victim_line | data.way_lines[w];
        end
        // store has not seen the pending write yet
        if (wbuf_on_victim)
            victim_line[wbuf_bank*WORD_BITS +: WORD_BITS] =
                merge_bytes(victim_line[wbuf_bank*WORD_BITS +: WORD_BITS], wbuf_data, wbuf_strb);
    end

    assign lookup_rdata = merge_bytes(hit_word, wbuf_data, fwd_strb);
    assign refill_word  = (req_write && (refill_cnt == req_bank))
                          ? merge_bytes(ret_data, req_wdata, req_wstrb) : ret_data;

    always_comb begin
        state_next = state;
        case (state)
            cache_ctrl_pkg::IDLE: begin
                if (addr_ok)
                    state_next = cache_ctrl_pkg::LOOKUP;
            end
            cache_ctrl_pkg::LOOKUP: begin
                if (hit)
                    state_next = addr_ok ? cache_ctrl_pkg::LOOKUP : cache_ctrl_pkg::IDLE;
                else if (victim_dirty)
                    state_next = cache_ctrl_pkg::DIRTY_MISS;
                else
                    state_next = cache_ctrl_pkg::MISS;
            end
            cache_ctrl_pkg::MISS: begin
                if (rd_rdy)
                    state_next = cache_ctrl_pkg::REFILL;
            end
            cache_ctrl_pkg::DIRTY_MISS: begin
                if (wr_rdy)
                    state_next = cache_ctrl_pkg::REPLACE;
            end
            cache_ctrl_pkg::REPLACE: begin
                if (rd_rdy)
                    state_next = cache_ctrl_pkg::REFILL;
            end
            cache_ctrl_pkg::REFILL: begin
                if (ret_valid && ret_last)
                    state_next = cache_ctrl_pkg::IDLE;
            end
            default: state_next = cache_ctrl_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= cache_ctrl_pkg::IDLE;
            wbuf_busy     <= 1'b0;
            first_replace <= 1'b0;
            refill_cnt    <= '0;
        end else begin
            state         <= state_next;
            wbuf_busy     <= hit_write;  // commits next cycle
            first_replace <= (state == cache_ctrl_pkg::DIRTY_MISS) && wr_rdy;
            if (in_refill && ret_valid)
                refill_cnt <= refill_cnt + 1'b1;  // wraps on the last word
        end
    end

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            req_op    <= op;
            req_tag   <= addr[cache_geom_pkg::ADDR_BITS-1 -: TAG_BITS];
            req_index <= addr[OFFSET_BITS +: INDEX_BITS];
            req_bank  <= addr[OFFSET_BITS-1 -: BANK_BITS];
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
        if (in_lookup) begin
            rep_way  <= tags.victim_way;
            rep_tag  <= tags.victim_tag;
            rep_line <= victim_line;
        end
        if (hit_write) begin
            wbuf_way   <= tags.hit_way;
            wbuf_index <= req_index;
            wbuf_bank  <= req_bank;
            wbuf_strb  <= req_wstrb;
            wbuf_data  <= req_wdata;
        end
    end

    assign tags.lookup_index   = req_index;
    assign tags.lookup_tag     = req_tag;
    assign tags.fill_en        = fill_done;
    assign tags.fill_way       = rep_way;
    assign tags.fill_tag       = req_tag;
    assign tags.dirty_set_en   = hit_write || (fill_done && req_write);
    assign tags.dirty_way      = in_lookup ? tags.hit_way : rep_way;
    assign tags.victim_advance = fill_done;

    // refill words own the write port, otherwise the write buffer
    assign data.rd_index = req_index;
    assign data.rd_bank  = req_bank;
    assign data.wr_en    = in_refill ? ret_valid : wbuf_busy;
    assign data.wr_index = in_refill ? req_index : wbuf_index;
    assign data.wr_way   = in_refill ? rep_way : wbuf_way;
    assign data.wr_bank  = in_refill ? refill_cnt : wbuf_bank;
    assign data.wr_strb  = in_refill ? {STRB_BITS{1'b1}} : wbuf_strb;
    assign data.wr_data  = in_refill ? refill_word : wbuf_data;

    assign data_ok = (in_lookup && (hit || req_write))
                     || (in_refill && ret_valid && !req_write && (refill_cnt == req_bank));
    assign rdata   = in_lookup ? lookup_rdata : refill_word;

    assign rd_req  = (state == cache_ctrl_pkg::MISS) || (state == cache_ctrl_pkg::REPLACE);
    assign rd_addr = {req_tag, req_index, {OFFSET_BITS{1'b0}}};
    assign wr_req  = first_replace;
    assign wr_addr = {rep_tag, req_index, {OFFSET_BITS{1'b0}}};
    assign wr_data = rep_line;

endmodule

//--- src/data_array.sv
`timescale 1ns/10ps

module data_array #(
    parameter int NUM_WAY        = cache_geom_pkg::DEF_NUM_WAY,
    parameter int BYTES_PER_LINE = cache_geom_pkg::DEF_BYTES_PER_LINE,
    parameter int NUM_LINE       = cache_geom_pkg::DEF_NUM_LINE
) (
    input logic   clk,
    data_if.store data
);
    localparam int WORD_BITS = cache_geom_pkg::WORD_BITS;
    localparam int STRB_BITS = cache_geom_pkg::STRB_BITS;
    localparam int WORDS     = BYTES_PER_LINE / STRB_BITS;

    logic [WORD_BITS-1:0] mem [NUM_WAY][NUM_LINE][WORDS];

    // one word of one way per cycle, byte granular
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAY; w++) begin
            for (int b = 0; b < STRB_BITS; b++) begin
                if (data.wr_en && data.wr_way[w] && data.wr_strb[b])
                    mem[w][data.wr_index][data.wr_bank][b*8 +: 8] <= data.wr_data[b*8 +: 8];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAY; w++) begin
            data.way_words[w] = mem[w][data.rd_index][data.rd_bank];
            for (int k = 0; k < WORDS; k++) begin
                data.way_lines[w][k*WORD_BITS +: WORD_BITS] = mem[w][data.rd_index][k];
            end
        end
    end

endmodule

//--- src/tag_array.sv
`timescale 1ns/10ps

module tag_array #(
    parameter int NUM_WAY        = cache_geom_pkg::DEF_NUM_WAY,
    parameter int BYTES_PER_LINE = cache_geom_pkg::DEF_BYTES_PER_LINE,
    parameter int NUM_LINE       = cache_geom_pkg::DEF_NUM_LINE
) (
    input logic  clk,
    input logic  reset,
    tag_if.store tags
);
    localparam int INDEX_BITS = $clog2(NUM_LINE);
    localparam int TAG_BITS   = cache_geom_pkg::ADDR_BITS - $clog2(BYTES_PER_LINE) - INDEX_BITS;
    localparam int PTR_BITS   = (NUM_WAY > 1) ? $clog2(NUM_WAY) : 1;

    logic [TAG_BITS-1:0]   tag_mem [NUM_LINE][NUM_WAY];
    logic [NUM_WAY-1:0]    valid_mem [NUM_LINE];
    logic [NUM_WAY-1:0]    dirty_mem [NUM_LINE];
    logic [PTR_BITS-1:0]   rr_mem [NUM_LINE];    // round-robin way per set

    logic [INDEX_BITS-1:0] idx;
    logic [NUM_WAY-1:0]    valid_set;
    logic [NUM_WAY-1:0]    fill_mask;
    logic [NUM_WAY-1:0]    set_mask;
    logic                  free_found;

    assign idx             = tags.lookup_index;
    assign valid_set       = valid_mem[idx];
    assign tags.valid_ways = valid_set;
    assign tags.dirty_ways = dirty_mem[idx];

    assign fill_mask = tags.fill_en ? tags.fill_way : '0;
    assign set_mask  = tags.dirty_set_en ? tags.dirty_way : '0;

    always_comb begin
        tags.victim_way = '0;
        tags.victim_tag = '0;
        free_found      = 1'b0;
        for (int w = 0; w < NUM_WAY; w++) begin
            tags.hit_way[w] = valid_set[w] && (tag_mem[idx][w] == tags.lookup_tag);
            if (!valid_set[w] && !free_found) begin
                tags.victim_way[w] = 1'b1;  // lowest invalid way first
                free_found         = 1'b1;
            end
        end
        if (!free_found)
            tags.victim_way[rr_mem[idx]] = 1'b1;
        for (int w = 0; w < NUM_WAY; w++) begin
            if (tags.victim_way[w])
                tags.victim_tag = tags.victim_tag | tag_mem[idx][w];
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAY; w++) begin
            if (fill_mask[w])
                tag_mem[idx][w] <= tags.fill_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < NUM_LINE; s++) begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
                rr_mem[s]    <= '0;
            end
        end else begin
            valid_mem[idx] <= valid_mem[idx] | fill_mask;
            // fill clears, a write sets; set wins for a write miss
            dirty_mem[idx] <= (dirty_mem[idx] & ~fill_mask) | set_mask;
            if (tags.victim_advance) begin
                if (rr_mem[idx] == PTR_BITS'(NUM_WAY - 1))
                    rr_mem[idx] <= '0;
                else
                    rr_mem[idx] <= rr_mem[idx] + 1'b1;
            end
        end
    end

endmodule

//--- src/data_if.sv
`timescale 1ns/10ps

interface data_if #(
    parameter int NUM_WAY        = cache_geom_pkg::DEF_NUM_WAY,
    parameter int BYTES_PER_LINE = cache_geom_pkg::DEF_BYTES_PER_LINE,
    parameter int NUM_LINE       = cache_geom_pkg::DEF_NUM_LINE
);
    localparam int WORD_BITS  = cache_geom_pkg::WORD_BITS;
    localparam int STRB_BITS  = cache_geom_pkg::STRB_BITS;
    localparam int INDEX_BITS = $clog2(NUM_LINE);
    localparam int BANK_BITS  = $clog2(BYTES_PER_LINE / STRB_BITS);

    logic [INDEX_BITS-1:0] rd_index;
    logic [BANK_BITS-1:0]  rd_bank;
    logic                  wr_en;
    logic [INDEX_BITS-1:0] wr_index;
    logic [NUM_WAY-1:0]    wr_way;      // one-hot
    logic [BANK_BITS-1:0]  wr_bank;
    logic [STRB_BITS-1:0]  wr_strb;
    logic [WORD_BITS-1:0]  wr_data;

    logic [NUM_WAY-1:0][WORD_BITS-1:0]        way_words;  // rd_bank word of each way
    logic [NUM_WAY-1:0][BYTES_PER_LINE*8-1:0] way_lines;

    modport ctrl (
        output rd_index, rd_bank,
        output wr_en, wr_index, wr_way, wr_bank, wr_strb, wr_data,
        input  way_words, way_lines
    );

    modport store (
        input  rd_index, rd_bank,
        input  wr_en, wr_index, wr_way, wr_bank, wr_strb, wr_data,
        output way_words, way_lines
    );

endinterface

//--- src/tag_if.sv
`timescale 1ns/10ps

interface tag_if #(
    parameter int NUM_WAY        = cache_geom_pkg::DEF_NUM_WAY,
    parameter int BYTES_PER_LINE = cache_geom_pkg::DEF_BYTES_PER_LINE,
    parameter int NUM_LINE       = cache_geom_pkg::DEF_NUM_LINE
);
    localparam int INDEX_BITS = $clog2(NUM_LINE);
    localparam int TAG_BITS   = cache_geom_pkg::ADDR_BITS - $clog2(BYTES_PER_LINE) - INDEX_BITS;

    logic [INDEX_BITS-1:0] lookup_index;
    logic [TAG_BITS-1:0]   lookup_tag;
    logic                  fill_en;
    logic [NUM_WAY-1:0]    fill_way;       // one-hot
    logic [TAG_BITS-1:0]   fill_tag;
    logic                  dirty_set_en;
    logic [NUM_WAY-1:0]    dirty_way;      // one-hot
    logic                  victim_advance;

    logic [NUM_WAY-1:0]    hit_way;        // one-hot
    logic [NUM_WAY-1:0]    valid_ways;
    logic [NUM_WAY-1:0]    dirty_ways;
    logic [NUM_WAY-1:0]    victim_way;     // one-hot
    logic [TAG_BITS-1:0]   victim_tag;

    modport ctrl (
        output lookup_index, lookup_tag, fill_en, fill_way, fill_tag,
        output dirty_set_en, dirty_way, victim_advance,
        input  hit_way, valid_ways, dirty_ways, victim_way, victim_tag
    );

    modport store (
        input  lookup_index, lookup_tag, fill_en, fill_way, fill_tag,
        input  dirty_set_en, dirty_way, victim_advance,
        output hit_way, valid_ways, dirty_ways, victim_way, victim_tag
    );

endinterface

//--- src/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,        // clean victim, line read only
        DIRTY_MISS,  // waiting for wr_rdy
        REPLACE,
        REFILL
    } cache_state_e;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } mem_op_e;

endpackage

//--- src/cache_geom_pkg.sv
package cache_geom_pkg;

    localparam int WORD_BITS = 32;              // processor word
    localparam int STRB_BITS = WORD_BITS / 8;   // one strobe per byte
    localparam int ADDR_BITS = 32;

    // geometry defaults, the top level passes these down as parameters
    localparam int DEF_NUM_WAY        = 2;
    localparam int DEF_BYTES_PER_LINE = 16;
    localparam int DEF_NUM_LINE       = 16;

endpackage
